// File: rtl/realign_pkg.sv
package realign_pkg;

  // stream word geometry, fixed for this realigner
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned NUM_BYTES  = DATA_WIDTH / 8; // bytes per word

  // one stream data word
  typedef logic [DATA_WIDTH-1:0] word_t;

  // byte offset of a line start inside a memory word
  typedef logic [$clog2(NUM_BYTES)-1:0] offset_t;

  // run sequencer states
  typedef enum logic [1:0] {
    IDLE = 2'b00, // waiting for start
    RUN  = 2'b01, // streaming lines
    DONE = 2'b10  // one-cycle end marker
  } ctrl_state_t;

endpackage

// File: rtl/word_stream_intf.sv
`timescale 1ns/1ps

// valid/ready word stream, transfer when valid & ready on a rising edge
interface word_stream_intf
  import realign_pkg::*;
();

  logic  valid; // driven by source
  logic  ready; // driven by sink
  word_t data;  // must hold while valid & ~ready

  modport source (
    output valid,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    output ready
  );

endinterface

// File: rtl/realign_ctrl_fsm.sv
`timescale 1ns/1ps

module realign_ctrl_fsm
  import realign_pkg::*;
#(
  parameter int unsigned CNT_WIDTH = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  offset_t              offset_i,
  input  logic [CNT_WIDTH-1:0] line_len_i,
  input  logic [CNT_WIDTH-1:0] n_lines_i,
  input  logic                 in_xfer_i,    // input handshake from the data path
  input  logic                 final_word_i, // last word of last line
  output logic                 run_active_o,
  output offset_t              offset_o,
  output logic [CNT_WIDTH-1:0] line_len_o,
  output logic [CNT_WIDTH-1:0] n_lines_o,
  output logic                 busy_o,
  output logic                 done_o
);

  ctrl_state_t          state_q, state_d;
  offset_t              offset_q;
  logic [CNT_WIDTH-1:0] line_len_q;
  logic [CNT_WIDTH-1:0] n_lines_q;
  logic                 start_ok; // start seen while idle

  assign start_ok = (state_q == IDLE) & start_i;

  // next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = RUN;
        end
      end
      RUN: begin
        // leave once the very last input word is taken
        if (in_xfer_i & final_word_i) begin
          state_d = DONE;
        end
      end
      DONE: begin
        state_d = IDLE; // single cycle marker
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // run settings stay frozen for the whole run
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= '0;
      line_len_q <= '0;
      n_lines_q  <= '0;
    end else if (start_ok) begin
      offset_q   <= offset_i;
      line_len_q <= line_len_i;
      n_lines_q  <= n_lines_i;
    end
  end

  assign run_active_o = (state_q == RUN);
  assign busy_o       = (state_q == RUN);  // drops together with done
  assign done_o       = (state_q == DONE);
  assign offset_o     = offset_q;
  assign line_len_o   = line_len_q;
  assign n_lines_o    = n_lines_q;

  // a new start must wait until the current run has finished
  a_no_start_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_o |-> !start_i);

  // done is a one-cycle pulse
  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o);

endmodule

// File: rtl/line_word_counter.sv
`timescale 1ns/1ps

module line_word_counter
  import realign_pkg::*;
#(
  parameter int unsigned CNT_WIDTH = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 run_active_i,
  input  offset_t              offset_i,
  input  logic [CNT_WIDTH-1:0] line_len_i,
  input  logic [CNT_WIDTH-1:0] n_lines_i,
  input  logic                 in_xfer_i,
  output logic                 first_word_o,
  output logic                 last_word_o,
  output logic                 final_word_o
);

  logic                 misaligned;     // line spans one extra memory word
  logic [CNT_WIDTH:0]   words_per_line; // one bit wider, line_len + 1 may overflow
  logic [CNT_WIDTH:0]   last_idx;
  logic [CNT_WIDTH-1:0] last_line;
  logic [CNT_WIDTH:0]   word_cnt_q;     // input words taken in current line
  logic [CNT_WIDTH-1:0] line_cnt_q;     // completed lines

  assign misaligned = (offset_i != '0);

  // aligned lines are line_len words, misaligned ones line_len + 1
  assign words_per_line = {1'b0, line_len_i} + {{CNT_WIDTH{1'b0}}, misaligned};
  assign last_idx       = words_per_line - 1'b1;
  assign last_line      = n_lines_i - 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_cnt_q <= '0;
      line_cnt_q <= '0;
    end else if (!run_active_i) begin
      // idle or done, start each run from zero
      word_cnt_q <= '0;
      line_cnt_q <= '0;
    end else if (in_xfer_i) begin
      if (last_word_o) begin
        word_cnt_q <= '0;             // wrap to next line
        line_cnt_q <= line_cnt_q + 1'b1;
      end else begin
        word_cnt_q <= word_cnt_q + 1'b1;
      end
    end
  end

  assign first_word_o = (word_cnt_q == '0);
  assign last_word_o  = (word_cnt_q == last_idx);
  assign final_word_o = last_word_o & (line_cnt_q == last_line); // end of run

  // the word count wraps at the line end and never runs past it
  a_word_cnt_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    run_active_i |-> word_cnt_q < words_per_line);

endmodule

// File: rtl/stream_realigner.sv
`timescale 1ns/1ps

module stream_realigner
  import realign_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            run_active_i,
  input  logic            first_word_i, // word count at zero
  input  logic            last_word_i,  // line's last input word
  input  offset_t         offset_i,
  word_stream_intf.sink   in_s,
  word_stream_intf.source out_s,
  output logic            in_xfer_o
);

  localparam int unsigned SHIFT_W = $clog2(DATA_WIDTH) + 1; // holds 0..DATA_WIDTH

  word_t              prev_q;     // previous input word
  logic               misaligned;
  logic               absorb;     // first word of a misaligned line
  logic [SHIFT_W-1:0] shift_dn;   // bits dropped from the previous word
  logic [SHIFT_W-1:0] shift_up;   // bits the current word moves up
  word_t              merged;

  assign misaligned = (offset_i != '0);
  assign absorb     = misaligned & first_word_i;

  // handshake
  // the absorbed word is taken without waiting on the output side
  assign in_s.ready  = run_active_i & (absorb | out_s.ready);
  assign out_s.valid = run_active_i & in_s.valid & ~absorb;
  assign in_xfer_o   = in_s.valid & in_s.ready;

  // keep each accepted word, its upper bytes feed the next output
  always_ff @(posedge clk_i) begin
    if (in_xfer_o) begin
      prev_q <= in_s.data;
    end
  end

  // byte shifts in bits
  always_comb begin
    shift_dn = SHIFT_W'(offset_i) << 3;
    shift_up = SHIFT_W'(DATA_WIDTH) - shift_dn;
  end

  // little endian merge
  // low bytes are prev[offset..3], high bytes are cur[0..offset-1]
  always_comb begin
    merged = (prev_q >> shift_dn) | (in_s.data << shift_up);
  end

  // zero latency, output follows the current input word
  assign out_s.data = misaligned ? merged : in_s.data;

  // a stalled output word must not change
  a_out_data_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_s.valid && !out_s.ready |=> $stable(out_s.data));

  // the line's last input word always completes an output word
  a_last_word_out: assert property (@(posedge clk_i) disable iff (!rst_ni)
    run_active_i && last_word_i && in_xfer_o |-> out_s.valid && out_s.ready);

endmodule

// File: rtl/source_realign_top.sv
`timescale 1ns/1ps

module source_realign_top
  import realign_pkg::*;
#(
  parameter int unsigned CNT_WIDTH = 16 // line length and line count width
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  offset_t              offset_i,
  input  logic [CNT_WIDTH-1:0] line_len_i, // logical words per line
  input  logic [CNT_WIDTH-1:0] n_lines_i,
  input  logic                 in_valid_i,
  input  word_t                in_data_i,
  output logic                 in_ready_o,
  output logic                 out_valid_o,
  output word_t                out_data_o,
  input  logic                 out_ready_i,
  output logic                 busy_o,
  output logic                 done_o
);

  word_stream_intf in_s ();  // memory side
  word_stream_intf out_s (); // aligned side

  logic                 run_active;
  offset_t              offset;
  logic [CNT_WIDTH-1:0] line_len;
  logic [CNT_WIDTH-1:0] n_lines;
  logic                 first_word;
  logic                 last_word;
  logic                 final_word;
  logic                 in_xfer;

  // port to interface
  assign in_s.valid  = in_valid_i;
  assign in_s.data   = in_data_i;
  assign in_ready_o  = in_s.ready;
  assign out_valid_o = out_s.valid;
  assign out_data_o  = out_s.data;
  assign out_s.ready = out_ready_i;

  realign_ctrl_fsm #(
    .CNT_WIDTH ( CNT_WIDTH )
  ) u_ctrl (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .start_i      ( start_i    ),
    .offset_i     ( offset_i   ),
    .line_len_i   ( line_len_i ),
    .n_lines_i    ( n_lines_i  ),
    .in_xfer_i    ( in_xfer    ),
    .final_word_i ( final_word ),
    .run_active_o ( run_active ),
    .offset_o     ( offset     ),
    .line_len_o   ( line_len   ),
    .n_lines_o    ( n_lines    ),
    .busy_o       ( busy_o     ),
    .done_o       ( done_o     )
  );

  line_word_counter #(
    .CNT_WIDTH ( CNT_WIDTH )
  ) u_counter (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .run_active_i ( run_active ),
    .offset_i     ( offset     ),
    .line_len_i   ( line_len   ),
    .n_lines_i    ( n_lines    ),
    .in_xfer_i    ( in_xfer    ),
    .first_word_o ( first_word ),
    .last_word_o  ( last_word  ),
    .final_word_o ( final_word )
  );

  stream_realigner u_realigner (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .run_active_i ( run_active ),
    .first_word_i ( first_word ),
    .last_word_i  ( last_word  ),
    .offset_i     ( offset     ),
    .in_s         ( in_s       ),
    .out_s        ( out_s      ),
    .in_xfer_o    ( in_xfer    )
  );

endmodule

// File: testbench/tb_source_realign.sv
`timescale 1ns/1ps

module tb_source_realign
  import realign_pkg::*;
();

  localparam int unsigned CNT_W = 16; // same as the top level default
  localparam VEC_FILE = "testbench/realign_vectors.txt";

  logic             clk;
  logic             rst_n;
  logic             start;
  offset_t          offset;
  logic [CNT_W-1:0] line_len;
  logic [CNT_W-1:0] n_lines;
  logic             in_valid;
  word_t            in_data;
  logic             in_ready;
  logic             out_valid;
  word_t            out_data;
  logic             out_ready;
  logic             busy;
  logic             done;

  // case table, one entry per case in the vector file
  int    case_off[$];
  int    case_len[$];
  int    case_lines[$];
  int    case_nin[$];
  int    case_nout[$];
  word_t in_words[$];  // all input words, cases back to back
  word_t exp_words[$]; // all expected output words

  integer seed;
  int     cycle_cnt;
  int     cycle_limit; // zero until the vectors are loaded
  int     in_base;
  int     exp_base;

  source_realign_top u_dut (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .start_i     ( start     ),
    .offset_i    ( offset    ),
    .line_len_i  ( line_len  ),
    .n_lines_i   ( n_lines   ),
    .in_valid_i  ( in_valid  ),
    .in_data_i   ( in_data   ),
    .in_ready_o  ( in_ready  ),
    .out_valid_o ( out_valid ),
    .out_data_o  ( out_data  ),
    .out_ready_i ( out_ready ),
    .busy_o      ( busy      ),
    .done_o      ( done      )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_word(input word_t got, input word_t exp, input int idx);
    if (got !== exp) begin
      fail_now($sformatf("error at %0t ns: output word %0d is %h, expected %h",
                         $time, idx, got, exp));
    end
  endtask

  task automatic check_done(input logic got_busy, input logic got_done,
                            input logic exp_busy, input logic exp_done);
    if (got_busy !== exp_busy || got_done !== exp_done) begin
      fail_now($sformatf("error at %0t ns: busy=%b done=%b, expected busy=%b done=%b",
                         $time, got_busy, got_done, exp_busy, exp_done));
    end
  endtask

  // run limit, so a missing done cannot hang the simulation
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      fail_now($sformatf("timeout, done was not seen within %0d cycles", cycle_limit));
    end
  end

  task automatic load_vectors();
    int                fd;
    int                r;
    int                n;
    int                i;
    int                v_off;
    int                v_len;
    int                v_lines;
    word_t             w;
    logic [8*16-1:0]   tok;
    logic [8*256-1:0]  rest;
    bit                more;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      fail_now("could not open the vector file testbench/realign_vectors.txt");
    end
    more = 1'b1;
    while (more) begin
      r = $fscanf(fd, "%s", tok);
      if (r != 1) begin
        more = 1'b0; // end of file
      end else if (tok == "#") begin
        r = $fgets(rest, fd); // drop comment text
      end else if (tok == "case") begin
        r = $fscanf(fd, "%d %d %d", v_off, v_len, v_lines);
        case_off.push_back(v_off);
        case_len.push_back(v_len);
        case_lines.push_back(v_lines);
      end else if (tok == "in") begin
        r = $fscanf(fd, "%d", n);
        case_nin.push_back(n);
        for (i = 0; i < n; i++) begin
          r = $fscanf(fd, "%h", w);
          in_words.push_back(w);
        end
      end else if (tok == "out") begin
        r = $fscanf(fd, "%d", n);
        case_nout.push_back(n);
        for (i = 0; i < n; i++) begin
          r = $fscanf(fd, "%h", w);
          exp_words.push_back(w);
        end
      end else begin
        fail_now("the vector file holds an unknown keyword");
      end
    end
    $fclose(fd);
  endtask

  // word counts per case must fit the line rules
  task automatic check_vector_table();
    int c;
    int per_line;
    if (case_nin.size() != case_off.size() || case_nout.size() != case_off.size()) begin
      fail_now("the vector file has a case without its in or out list");
    end
    for (c = 0; c < case_off.size(); c++) begin
      per_line = case_len[c] + ((case_off[c] != 0) ? 1 : 0); // extra memory word if misaligned
      if (case_nin[c] != per_line * case_lines[c] ||
          case_nout[c] != case_len[c] * case_lines[c]) begin
        fail_now($sformatf("vector case %0d has word counts that do not fit its settings", c));
      end
    end
  endtask

  task automatic run_case(input int c, input int in_ofs, input int exp_ofs);
    int in_idx;
    int out_idx;
    bit finished;
    bit stalled; // word presented last cycle and not taken
    in_idx   = 0;
    out_idx  = 0;
    finished = 1'b0;
    stalled  = 1'b0;
    start    <= 1'b1;
    offset   <= offset_t'(case_off[c]);
    line_len <= CNT_W'(case_len[c]);
    n_lines  <= CNT_W'(case_lines[c]);
    @(posedge clk);
    start <= 1'b0;
    while (!finished) begin
      // input side keeps a word until it is accepted
      if (!stalled) begin
        if (in_idx < case_nin[c]) begin
          in_valid <= (($unsigned($random(seed)) % 4) != 0);
          in_data  <= in_words[in_ofs + in_idx];
        end else begin
          in_valid <= 1'b0;
        end
      end
      out_ready <= (($unsigned($random(seed)) % 3) != 0); // random stalls
      @(posedge clk);
      if (out_valid && out_ready) begin
        if (out_idx >= case_nout[c]) begin
          fail_now($sformatf("case %0d produced more output words than expected", c));
        end else begin
          check_word(out_data, exp_words[exp_ofs + out_idx], out_idx);
        end
        out_idx++;
      end
      stalled = in_valid && !in_ready;
      if (in_valid && in_ready) begin
        in_idx++;
      end
      if (done) begin
        if (out_idx != case_nout[c]) begin
          fail_now($sformatf("case %0d signalled done before all output words came", c));
        end
        check_done(busy, done, 1'b0, 1'b1); // busy drops with done
        finished = 1'b1;
      end else begin
        check_done(busy, done, 1'b1, 1'b0);
      end
    end
    in_valid <= 1'b0;
    @(posedge clk);
    check_done(busy, done, 1'b0, 1'b0); // single pulse
    if (out_valid || in_ready) begin
      fail_now("the stream handshake is active while the realigner is idle");
    end
  endtask

  initial begin
    seed        = 93307;
    cycle_cnt   = 0;
    cycle_limit = 0;
    rst_n       = 1'b0;
    start       = 1'b0;
    offset      = '0;
    line_len    = '0;
    n_lines     = '0;
    in_valid    = 1'b0;
    in_data     = '0;
    out_ready   = 1'b0;
    load_vectors();
    check_vector_table();
    cycle_limit = 8 * in_words.size() + 200;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_done(busy, done, 1'b0, 1'b0);
    if (out_valid || in_ready) begin
      fail_now("the stream handshake is active after reset");
    end
    in_base  = 0;
    exp_base = 0;
    for (int c = 0; c < case_off.size(); c++) begin
      run_case(c, in_base, exp_base); // each case is a fresh start
      in_base  = in_base + case_nin[c];
      exp_base = exp_base + case_nout[c];
    end
    $display("No errors");
    $finish;
  end

endmodule

// File: testbench/realign_vectors.txt
# case <offset> <line_len> <n_lines>, then in <count> <words>, then out <count> <words>
# words are hex, inputs in stream order, outputs in expected order
#
# aligned pass-through over two lines
case 0 3 2
in 6 01234567 89abcdef 0f1e2d3c 4b5a6978 87968574 c3d2e1f0
out 6 01234567 89abcdef 0f1e2d3c 4b5a6978 87968574 c3d2e1f0

# offset 1, single line
case 1 2 1
in 3 33221100 77665544 bbaa9988
out 2 44332211 88776655

# offset 2, two lines so the second first word is absorbed
case 2 2 2
in 6 03020100 07060504 0b0a0908 13121110 17161514 1b1a1918
out 4 05040302 09080706 15141312 19181716

# offset 3, one longer line
case 3 3 1
in 4 a3a2a1a0 a7a6a5a4 abaaa9a8 afaeadac
out 3 a6a5a4a3 aaa9a8a7 aeadacab

# offset 1, three short lines
case 1 1 3
in 6 44332211 88776655 ccbbaa99 00ffeedd 0d0c0b0a 1d1c1b1a
out 3 55443322 ddccbbaa 1a0d0c0b

# aligned again after misaligned runs
case 0 2 1
in 2 deadbeef cafef00d
out 2 deadbeef cafef00d

# offset 2, one word per line
case 2 1 1
in 2 12345678 9abcdef0
out 1 def01234

// File: list.f
rtl/realign_pkg.sv
rtl/word_stream_intf.sv
rtl/realign_ctrl_fsm.sv
rtl/line_word_counter.sv
rtl/stream_realigner.sv
rtl/source_realign_top.sv
testbench/tb_source_realign.sv

// File: Bender.yml
package:
  name: source_realign

dependencies: {}

sources:
  # package and interface first
  - rtl/realign_pkg.sv
  - rtl/word_stream_intf.sv
  - rtl/realign_ctrl_fsm.sv
  - rtl/line_word_counter.sv
  - rtl/stream_realigner.sv
  - rtl/source_realign_top.sv

  - target: test
    files:
      - testbench/tb_source_realign.sv
